// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_error_propagator
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SIMULATION FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "sim: failure reported, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/ep_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module ep_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         valid,
    input  backprop_pkg::delta_out_vec_t delta_out,
    input  logic                         error,
    input  logic                         push,
    input  int                           push_id,
    input  backprop_pkg::delta_out_vec_t push_delta,
    input  logic                         push_error,
    output int                           n_done,
    output int                           n_errors,
    output int                           n_pending
);

    import backprop_pkg::*;

    typedef struct packed {
        int             id;
        delta_out_vec_t delta;
        logic           error;
    } exp_t;

    exp_t exp_q [$];
    int   done_cnt  = 0;
    int   err_cnt   = 0;
    int   pend_cnt  = 0;
    bit   after_rst = 1'b0;  // one more quiet check right after reset drops

    assign n_done    = done_cnt;
    assign n_errors  = err_cnt;
    assign n_pending = pend_cnt;

    // sampled on the falling edge halfway between DUT updates
    always @(negedge clk) begin : watch
        exp_t e;
        bit   bad;
        if (rst || after_rst) begin
            if (valid !== 1'b0) begin
                $display("[ERROR] %0t ns: valid expected 0 got %b", $time, valid);
                err_cnt++;
            end
            if (error !== 1'b0) begin
                $display("[ERROR] %0t ns: error expected 0 got %b", $time, error);
                err_cnt++;
            end
        end
        after_rst = rst;
        if (!rst && push) exp_q.push_back('{id: push_id, delta: push_delta, error: push_error});
        if (!rst && valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("valid at %0t ns while no job was pending", $time);
                err_cnt++;
            end else begin
                e   = exp_q.pop_front();
                bad = 1'b0;
                for (int j = 0; j < ep_out_len; j++) begin
                    if (delta_out.lane[j] !== e.delta.lane[j]) begin
                        $display("[ERROR] %0t ns: delta_out.lane[%0d] expected %0d got %0d",
                                 $time, j, $signed(e.delta.lane[j]), $signed(delta_out.lane[j]));
                        err_cnt++;
                        bad = 1'b1;
                    end
                end
                if (error !== e.error) begin
                    $display("[ERROR] %0t ns: error expected %b got %b", $time, e.error, error);
                    err_cnt++;
                    bad = 1'b1;
                end
                done_cnt++;
                $display("test %0d %s: delta_out %0d %0d %0d %0d error %b", e.id,
                         bad ? "mismatch" : "ok", $signed(delta_out.lane[0]),
                         $signed(delta_out.lane[1]), $signed(delta_out.lane[2]),
                         $signed(delta_out.lane[3]), error);
            end
        end
        pend_cnt = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== dv/ep_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module ep_props (
    input logic                    clk,
    input logic                    rst,
    input logic                    start,
    input logic                    valid,
    input logic                    inner_start,
    input logic                    scale_start,
    input backprop_pkg::ep_state_e state
);

    import backprop_pkg::*;

    // an accepted start always lands after the fixed pipeline latency
    a_latency: assert property (@(posedge clk) disable iff (rst)
        (start && state == st_idle) |-> ##ep_latency valid)
        else $error("valid missing %0d cycles after an accepted start", ep_latency);

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
        else $error("valid high on two cycles in a row");

    a_inner_pulse: assert property (@(posedge clk) disable iff (rst) inner_start |=> !inner_start)
        else $error("inner_start longer than one cycle");

    a_scale_pulse: assert property (@(posedge clk) disable iff (rst) scale_start |=> !scale_start)
        else $error("scale_start longer than one cycle");

endmodule

bind error_propagator ep_props props_i (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .valid       (valid),
    .inner_start (inner_start),
    .scale_start (scale_start),
    .state       (state)
);

`default_nettype wire

// ==== dv/tb_error_propagator.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_error_propagator;

    import backprop_pkg::*;

    localparam int n_jobs   = 16;  // eight fixed rows, then random ones
    localparam int wait_max = 50;  // cycles allowed for one valid

    // weight literals list row 4 first and lane 3 first within a row
    localparam weight_mat_t w_ident = 160'h00000000_10000000_00100000_00001000_00000010;
    localparam weight_mat_t w_a     = 160'h09F114F8_F60AEE03_0B1805DD_30F9220C_E507F012;
    localparam weight_mat_t w_b     = 160'h1708E025_F2EC0D0B_1E03F714_FD1106E9_02F41A09;
    localparam weight_mat_t w_sat   = 160'h80807F7F_80807F7F_80807F7F_80807F7F_80807F7F;

    typedef struct packed {
        delta_in_vec_t  delta_in;
        z_vec_t         z;
        weight_mat_t    w;
        logic           busy_poke;  // second start while the job runs
        delta_out_vec_t exp_delta;
        logic           exp_error;
    } job_t;

    logic           clk = 1'b0;
    logic           rst;
    logic           start;
    delta_in_vec_t  delta_in;
    z_vec_t         z;
    weight_mat_t    w;
    delta_out_vec_t delta_out;
    logic           valid;
    logic           error;
    logic           push;
    int             push_id;
    delta_out_vec_t push_delta;
    logic           push_error;
    int             chk_done;
    int             chk_errors;
    int             chk_pending;
    act_t           deriv_tab [2**z_w];
    job_t           jobs [n_jobs];
    int             tb_errors;
    int             n_run;
    bit             timed_out;

    error_propagator dut_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .delta_in  (delta_in),
        .z         (z),
        .w         (w),
        .delta_out (delta_out),
        .valid     (valid),
        .error     (error)
    );

    ep_checker chk_i (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .delta_out  (delta_out),
        .error      (error),
        .push       (push),
        .push_id    (push_id),
        .push_delta (push_delta),
        .push_error (push_error),
        .n_done     (chk_done),
        .n_errors   (chk_errors),
        .n_pending  (chk_pending)
    );

    always #5 clk = ~clk;

    // transposed product, round half up, saturate, then scale by the table derivative
    function automatic void model_backprop(input delta_in_vec_t d, input z_vec_t zz,
                                           input weight_mat_t ww, output delta_out_vec_t res,
                                           output logic err);
        int acc;
        int wv;
        int dv;
        int sat;
        int scaled;
        err = 1'b0;
        for (int j = 0; j < ep_out_len; j++) begin
            acc = 0;
            for (int r = 0; r < ep_in_len; r++) begin
                wv  = $signed(ww.row[r].lane[j]);
                dv  = $signed(d.lane[r]);
                acc = acc + wv * dv;
            end
            sat = (acc + (1 << (frac_w - 1))) >>> frac_w;
            if (sat > 2**(delta_w-1) - 1) begin
                sat = 2**(delta_w-1) - 1;
                err = 1'b1;
            end else if (sat < -(2**(delta_w-1))) begin
                sat = -(2**(delta_w-1));
                err = 1'b1;
            end
            scaled = (sat * int'(deriv_tab[zz.lane[j]]) + (1 << (act_frac_w - 1))) >>> act_frac_w;
            res.lane[j] = delta_t'(scaled);
        end
    endfunction

    function automatic z_vec_t pack_z(input int a, input int b, input int c, input int d);
        z_vec_t v;
        v.lane[0] = z_t'(a);
        v.lane[1] = z_t'(b);
        v.lane[2] = z_t'(c);
        v.lane[3] = z_t'(d);
        return v;
    endfunction

    task automatic add_row(input int k, input delta_in_vec_t d, input z_vec_t zz,
                           input weight_mat_t ww, input logic poke);
        delta_out_vec_t res;
        logic           err;
        model_backprop(d, zz, ww, res, err);
        jobs[k] = '{delta_in: d, z: zz, w: ww, busy_poke: poke, exp_delta: res, exp_error: err};
    endtask

    task automatic add_random_row(input int k);
        delta_in_vec_t d;
        z_vec_t        zz;
        weight_mat_t   ww;
        for (int r = 0; r < ep_in_len; r++) begin
            d.lane[r] = delta_t'($urandom);
            for (int j = 0; j < ep_out_len; j++) begin
                // some rows stay unsaturated
                ww.row[r].lane[j] = weight_t'($urandom_range(63, 0) - 32);
            end
        end
        for (int j = 0; j < ep_out_len; j++) begin
            zz.lane[j] = z_t'($urandom);
        end
        add_row(k, d, zz, ww, 1'b0);
    endtask

    // the fixed rows cover all 32 z codes between them
    task automatic build_table();
        add_row(0, 40'h11_81_35_E8_20, pack_z(1, 2, 3, 31), w_ident, 1'b0);
        add_row(1, 40'h27_D9_0A_F3_1C, pack_z(4, 27, 5, 26), w_a, 1'b0);
        add_row(2, 40'hFA_0F_E6_2B_F0, pack_z(6, 25, 7, 24), w_b, 1'b0);
        add_row(3, 40'h7F_7F_7F_7F_7F, pack_z(0, 30, 29, 28), w_sat, 1'b0);
        add_row(4, 40'hFC_04_10_F8_08, pack_z(8, 23, 9, 22), w_a, 1'b0);  // clears error
        add_row(5, 40'h0C_E8_18_D0_30, pack_z(10, 21, 11, 20), w_b, 1'b1);
        add_row(6, 40'h00_20_E0_40_C0, pack_z(12, 19, 13, 18), w_a, 1'b0);
        add_row(7, 40'h55_FF_01_80_7F, pack_z(14, 17, 15, 16), w_b, 1'b0);
        for (int k = 8; k < n_jobs; k++) begin
            add_random_row(k);
        end
    endtask

    task automatic wait_for_valid(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < wait_max && !seen; n++) begin
            @(posedge clk);
            #1;
            if (valid) seen = 1'b1;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            #1;
            if (valid) begin
                $display("a second valid came at %0t ns after the ignored start", $time);
                tb_errors++;
            end
        end
    endtask

    task automatic run_job(input int k);
        bit seen;
        @(posedge clk);
        #1;
        start      = 1'b1;
        delta_in   = jobs[k].delta_in;
        z          = jobs[k].z;
        w          = jobs[k].w;
        push       = 1'b1;
        push_id    = k;
        push_delta = jobs[k].exp_delta;
        push_error = jobs[k].exp_error;
        @(posedge clk);
        #1;
        start = 1'b0;
        push  = 1'b0;
        if (jobs[k].busy_poke) begin
            repeat (3) @(posedge clk);
            #1;
            start    = 1'b1;  // lands while the MVM runs
            delta_in = ~jobs[k].delta_in;
            z        = ~jobs[k].z;
            w        = ~jobs[k].w;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        wait_for_valid(seen);
        n_run++;
        if (!seen) begin
            $display("test %0d: no valid within %0d cycles", k, wait_max);
            tb_errors++;
            timed_out = 1'b1;
        end else if (jobs[k].busy_poke) begin
            expect_quiet(ep_latency + 2);
        end
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        delta_in   = '0;
        z          = '0;
        w          = '0;
        push       = 1'b0;
        push_id    = 0;
        push_delta = '0;
        push_error = 1'b0;
        tb_errors  = 0;
        n_run      = 0;
        timed_out  = 1'b0;
        void'($urandom(80));
        $readmemh(deriv_file, deriv_tab);
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 0; k < n_jobs && !timed_out; k++) begin
            run_job(k);
        end
        repeat (3) @(posedge clk);
        if (chk_pending != 0) begin
            $display("%0d expected results never arrived", chk_pending);
            tb_errors++;
        end
        $display("jobs run %0d, results checked %0d, errors %0d", n_run, chk_done,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/backprop_pkg.sv ====
`default_nettype none

package backprop_pkg;

    localparam int ep_in_len  = 5;  // input deltas, weight rows
    localparam int ep_out_len = 4;  // output deltas, weight columns, z lanes
    localparam int delta_w    = 8;
    localparam int weight_w   = 8;
    localparam int frac_w     = 4;  // fraction bits of deltas and weights
    localparam int z_w        = 5;  // 32-entry derivative table
    localparam int act_w      = 9;
    localparam int act_frac_w = 8;
    localparam int ep_latency = 11; // accepted start to valid

    localparam int row_cnt_w  = $clog2(ep_in_len);
    localparam int acc_w      = delta_w + weight_w + $clog2(ep_in_len); // 5 summed products
    localparam int scale_w    = delta_w + act_w + 1;                    // delta times unsigned deriv
    localparam int sc_lanes   = 2;                                      // scaler lanes per cycle

    localparam string deriv_file = "hdl/sigmoid_deriv.mem";

    typedef logic signed [delta_w-1:0]  delta_t;
    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic        [z_w-1:0]      z_t;
    typedef logic        [act_w-1:0]    act_t;

    localparam delta_t delta_max = delta_t'(2**(delta_w-1) - 1);
    localparam delta_t delta_min = delta_t'(-(2**(delta_w-1)));

    typedef struct packed { delta_t [ep_in_len-1:0] lane; }       delta_in_vec_t;
    typedef struct packed { delta_t [ep_out_len-1:0] lane; }      delta_out_vec_t;
    typedef struct packed { weight_t [ep_out_len-1:0] lane; }     weight_row_t;
    typedef struct packed { weight_row_t [ep_in_len-1:0] row; }   weight_mat_t;
    typedef struct packed { z_t [ep_out_len-1:0] lane; }          z_vec_t;
    typedef struct packed { act_t [ep_out_len-1:0] lane; }        act_vec_t;

    typedef enum logic [1:0] {
        st_idle,
        st_mvm,   // matrix-vector product and table lookup running
        st_scale  // element-wise scaling running
    } ep_state_e;

endpackage

`default_nettype wire

// ==== hdl/error_propagator.sv ====
`timescale 1ns/1ns
`default_nettype none

module error_propagator (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  backprop_pkg::delta_in_vec_t  delta_in,
    input  backprop_pkg::z_vec_t         z,
    input  backprop_pkg::weight_mat_t    w,
    output backprop_pkg::delta_out_vec_t delta_out,
    output logic                         valid,
    output logic                         error
);

    import backprop_pkg::*;

    ep_state_e      state;
    logic           inner_start;    // launches the MVM and the table lookup
    logic           scale_start;
    logic           scale_start_d;  // scaler on its last lane pair
    delta_in_vec_t  delta_q;
    z_vec_t         z_q;
    weight_mat_t    w_q;
    delta_out_vec_t mvm_result;
    logic           mvm_valid;
    logic           mvm_error;
    act_vec_t       deriv;
    logic           lut_ready;

    weight_delta_mvm u_mvm (
        .clk    (clk),
        .rst    (rst),
        .start  (inner_start),
        .delta  (delta_q),
        .w      (w_q),
        .result (mvm_result),
        .valid  (mvm_valid),
        .error  (mvm_error)
    );

    sigmoid_deriv_lut u_lut (
        .clk    (clk),
        .rst    (rst),
        .start  (inner_start),
        .z      (z_q),
        .deriv  (deriv),
        .ready  (lut_ready)
    );

    hadamard_scaler u_scaler (
        .clk    (clk),
        .rst    (rst),
        .start  (scale_start),
        .delta  (mvm_result),
        .deriv  (deriv),
        .result (delta_out),
        .valid  (valid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= st_idle;
            inner_start   <= 1'b0;
            scale_start   <= 1'b0;
            scale_start_d <= 1'b0;
            error         <= 1'b0;
        end else begin
            inner_start   <= 1'b0;
            scale_start   <= 1'b0;
            scale_start_d <= scale_start;
            if (scale_start_d) error <= mvm_error;  // lands together with delta_out
            case (state)
                st_idle: begin
                    if (start) begin
                        state       <= st_mvm;
                        inner_start <= 1'b1;
                    end
                end
                st_mvm: begin
                    if (mvm_valid && lut_ready) begin
                        state       <= st_scale;
                        scale_start <= 1'b1;
                    end
                end
                st_scale: begin
                    if (valid) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // a start while busy is dropped, so the operands stay put for the whole job
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            delta_q <= delta_in;
            z_q     <= z;
            w_q     <= w;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hadamard_scaler.sv ====
`timescale 1ns/1ns
`default_nettype none

module hadamard_scaler (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  backprop_pkg::delta_out_vec_t delta,
    input  backprop_pkg::act_vec_t       deriv,
    output backprop_pkg::delta_out_vec_t result,
    output logic                         valid
);

    import backprop_pkg::*;

    logic                         pair;      // lane pair in the multipliers
    delta_t [sc_lanes-1:0]        delta_hi;  // upper lanes, used on the second cycle
    act_t   [sc_lanes-1:0]        deriv_hi;
    delta_t [sc_lanes-1:0]        lo_q;      // lanes 0-1 held until the upper pair is done
    delta_t [sc_lanes-1:0]        lane_res;

    for (genvar j = 0; j < sc_lanes; j++) begin : g_mul
        delta_t                    op_d;
        act_t                      op_a;
        logic signed [scale_w-1:0] scaled;

        assign op_d = pair ? delta_hi[j] : delta.lane[j];
        assign op_a = pair ? deriv_hi[j] : deriv.lane[j];
        // derivative is unsigned, so widen it with a zero sign bit
        assign scaled = (op_d * $signed({1'b0, op_a}) + scale_w'(1 << (act_frac_w - 1)))
                        >>> act_frac_w;
        assign lane_res[j] = scaled[delta_w-1:0];  // fits since |deriv| <= 0.25
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pair  <= 1'b0;
            valid <= 1'b0;
        end else begin
            pair  <= start;
            valid <= pair;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            delta_hi <= delta.lane[2*sc_lanes-1:sc_lanes];
            deriv_hi <= deriv.lane[2*sc_lanes-1:sc_lanes];
            lo_q     <= lane_res;
        end
        if (pair) begin
            result.lane[2*sc_lanes-1:sc_lanes] <= lane_res;
            result.lane[sc_lanes-1:0]          <= lo_q;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sigmoid_deriv.mem ====
// sigmoid derivative, 8 fraction bits; entry n is z code n, read as signed with 1 fraction bit
040
03C
032
026
01B
012
00C
007
005
003
002
001
001
000
000
000
000
000
000
000
001
001
002
003
005
007
00C
012
01B
026
032
03C

// ==== hdl/sigmoid_deriv_lut.sv ====
`timescale 1ns/1ns
`default_nettype none

module sigmoid_deriv_lut (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  backprop_pkg::z_vec_t  z,
    output backprop_pkg::act_vec_t deriv,
    output logic                  ready
);

    import backprop_pkg::*;

    act_t   rom [2**z_w];
    z_vec_t addr;  // address register in front of the ROM
    logic   rd;

    initial $readmemh(deriv_file, rom);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd    <= 1'b0;
            ready <= 1'b0;
        end else begin
            rd <= start;
            if (start) begin
                ready <= 1'b0;  // old entries no longer match
            end else if (rd) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) addr <= z;
        if (rd) begin
            for (int j = 0; j < ep_out_len; j++) begin
                deriv.lane[j] <= rom[addr.lane[j]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/weight_delta_mvm.sv ====
`timescale 1ns/1ns
`default_nettype none

module weight_delta_mvm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  backprop_pkg::delta_in_vec_t delta,
    input  backprop_pkg::weight_mat_t   w,
    output backprop_pkg::delta_out_vec_t result,
    output logic                        valid,
    output logic                        error
);

    import backprop_pkg::*;

    logic [row_cnt_w-1:0]                 row_idx;  // weight row and delta being summed
    logic                                 run;
    logic                                 fin;      // accumulators complete
    logic signed [acc_w-1:0]              acc  [ep_out_len];
    logic signed [weight_w+delta_w-1:0]   prod [ep_out_len];
    logic signed [acc_w-1:0]              rnd  [ep_out_len];
    delta_out_vec_t                       sat;
    logic [ep_out_len-1:0]                ovf;

    always_ff @(posedge clk) begin
        if (rst) begin
            run     <= 1'b0;
            fin     <= 1'b0;
            row_idx <= '0;
        end else begin
            fin <= 1'b0;
            if (start) begin
                run     <= 1'b1;
                row_idx <= '0;
            end else if (run) begin
                row_idx <= row_idx + row_cnt_w'(1);
                if (row_idx == row_cnt_w'(ep_in_len - 1)) begin
                    run <= 1'b0;
                    fin <= 1'b1;
                end
            end
        end
    end

    // column j of the transposed product takes w[r][j] * delta[r]
    always_comb begin
        for (int j = 0; j < ep_out_len; j++) begin
            prod[j] = w.row[row_idx].lane[j] * delta.lane[row_idx];
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < ep_out_len; j++) begin
            if (start) begin
                acc[j] <= '0;
            end else if (run) begin
                acc[j] <= acc[j] + prod[j];
            end
        end
    end

    always_comb begin
        for (int j = 0; j < ep_out_len; j++) begin
            rnd[j] = (acc[j] + acc_w'(1 << (frac_w - 1))) >>> frac_w; // round half up
            ovf[j] = 1'b1;
            if (rnd[j] > delta_max) begin
                sat.lane[j] = delta_max;
            end else if (rnd[j] < delta_min) begin
                sat.lane[j] = delta_min;
            end else begin
                sat.lane[j] = rnd[j][delta_w-1:0];
                ovf[j]      = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            error <= 1'b0;
        end else begin
            valid <= fin;
            if (fin) error <= |ovf;  // held until the next result
        end
    end

    always_ff @(posedge clk) begin
        if (fin) result <= sat;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/backprop_pkg.sv
hdl/weight_delta_mvm.sv
hdl/sigmoid_deriv_lut.sv
hdl/hadamard_scaler.sv
hdl/error_propagator.sv
dv/ep_props.sv
dv/ep_checker.sv
dv/tb_error_propagator.sv
